/* include/mopshub_defs.svh */
`ifndef MOPSHUB_DEFS_SVH
`define MOPSHUB_DEFS_SVH

// number of CAN bus controllers on the hub
`define NUM_BUS 32

// width of one receive word
`define WORD_W 16

// enough bits to index every bus
`define BUS_IDX_W 5

// delivered-message counter, wraps
`define COUNT_W 5

`endif

/* logic/can_bus_pkg.sv */
`include "mopshub_defs.svh"

package can_bus_pkg;

   localparam int NODE_ID_W  = 7;    // msg view node id
   localparam int PAYLOAD_W  = 8;
   localparam int ERR_CODE_W = 4;    // status view error code
   localparam int ERR_CNT_W  = 11;

   // bit 15 of every receive word
   typedef enum logic {
      KIND_MSG    = 1'b0,
      KIND_STATUS = 1'b1
   } word_kind_e;

   // one receive word, read either as a message or as bus status
   typedef union packed {
      logic [`WORD_W-1:0] raw;
      struct packed {
         word_kind_e             kind;
         logic [NODE_ID_W-1:0]   node_id;
         logic [PAYLOAD_W-1:0]   payload;
      } msg;
      struct packed {
         word_kind_e             kind;
         logic [ERR_CODE_W-1:0]  err_code;
         logic [ERR_CNT_W-1:0]   err_count;
      } status;
   } rx_word_u;

endpackage

/* logic/hub_ctrl_pkg.sv */
package hub_ctrl_pkg;

   // read sequence of the hub
   // idle -> select -> read -> irq -> done -> idle
   // irq can also fall straight back to idle on an abort
   typedef enum logic [2:0] {
      RD_IDLE   = 3'd0,   // waiting for enable and a pending bus
      RD_SELECT = 3'd1,   // bus index registered
      RD_READ   = 3'd2,   // word being captured
      RD_IRQ    = 3'd3,   // host interrupt raised, held by host
      RD_DONE   = 3'd4    // word accepted
   } rd_state_e;

endpackage

/* logic/bus_req_scanner.sv */
`timescale 1ns/10ps
`include "mopshub_defs.svh"

module bus_req_scanner (
   input  logic                  clock,
   input  logic                  rst,
   input  logic [`NUM_BUS-1:0]   can_rec,
   input  logic                  served,
   input  logic [`BUS_IDX_W-1:0] served_bus,
   output logic [`BUS_IDX_W-1:0] next_bus,
   output logic                  any_pending
);

   logic [`BUS_IDX_W-1:0] ptr;   // first bus looked at

   // pointer only moves once a word has really been delivered,
   // an aborted read leaves it so the same bus is tried again
   always_ff @(posedge clock) begin
      if (rst) begin
         ptr <= '0;
      end else if (served) begin
         ptr <= served_bus + 1'b1;   // wraps at NUM_BUS
      end
   end

   assign any_pending = |can_rec;

   // first set flag at or after ptr, with wrap-around
   always_comb begin
      logic                  found;
      logic [`BUS_IDX_W-1:0] idx;
      found    = 1'b0;
      next_bus = ptr;
      idx      = ptr;
      for (int i = 0; i < `NUM_BUS; i++) begin
         idx = ptr + `BUS_IDX_W'(i);   // modulo NUM_BUS by width
         if (!found && can_rec[idx]) begin
            found    = 1'b1;
            next_bus = idx;
         end
      end
   end

endmodule

/* logic/node_readdata_sm.sv */
`timescale 1ns/10ps
`include "mopshub_defs.svh"

module node_readdata_sm
   import hub_ctrl_pkg::*;
(
   input  logic                  clock,
   input  logic                  rst,
   input  logic                  ireqsucrec,
   input  logic                  endwait,
   input  logic                  restirq,
   input  logic                  any_pending,
   input  logic [`BUS_IDX_W-1:0] next_bus,
   output logic [`BUS_IDX_W-1:0] bus_rec_select,
   output logic                  init_bus_select,
   output logic                  capture,
   output logic                  irq_can_rec,
   output logic                  choose_bus_end,
   output logic                  deliver
);

   rd_state_e state;

   // single registered process; every output is a flop
   // request sampled at edge n, irq_can_rec high after edge n+2
   always_ff @(posedge clock) begin
      if (rst) begin
         state           <= RD_IDLE;
         bus_rec_select  <= '0;
         init_bus_select <= 1'b0;
         capture         <= 1'b0;
         irq_can_rec     <= 1'b0;
         choose_bus_end  <= 1'b0;
         deliver         <= 1'b0;
      end else begin
         // strobes last one cycle
         init_bus_select <= 1'b0;
         capture         <= 1'b0;
         choose_bus_end  <= 1'b0;
         deliver         <= 1'b0;

         case (state)
            RD_IDLE: begin
               if (ireqsucrec && any_pending) begin
                  bus_rec_select  <= next_bus;   // held until back in idle
                  init_bus_select <= 1'b1;
                  state           <= RD_SELECT;
               end
            end

            RD_SELECT: begin
               capture <= 1'b1;   // sink latches the word on the next edge
               state   <= RD_READ;
            end

            RD_READ: begin
               irq_can_rec <= 1'b1;   // word is valid from here on
               state       <= RD_IRQ;
            end

            // host holds us here as long as it likes,
            // nothing new is selected and can_rec is not looked at
            RD_IRQ: begin
               if (restirq) begin
                  irq_can_rec <= 1'b0;   // abort, no delivery
                  state       <= RD_IDLE;
               end else if (endwait) begin
                  irq_can_rec    <= 1'b0;
                  choose_bus_end <= 1'b1;
                  deliver        <= 1'b1;   // also advances the scanner
                  state          <= RD_DONE;
               end
            end

            RD_DONE: begin
               state <= RD_IDLE;   // scanner pointer settles here
            end

            default: begin
               state <= RD_IDLE;
            end
         endcase
      end
   end

endmodule

/* logic/rx_word_sink.sv */
`timescale 1ns/10ps
`include "mopshub_defs.svh"

module rx_word_sink
   import can_bus_pkg::*;
(
   input  logic                                clock,
   input  logic                                rst,
   input  logic [`NUM_BUS-1:0][`WORD_W-1:0]    readdata_bus,
   input  logic [`BUS_IDX_W-1:0]               bus_rec_select,
   input  logic                                capture,
   input  logic                                deliver,
   output logic [`WORD_W-1:0]                  readdata,
   output logic [NODE_ID_W-1:0]                node_id,
   output logic                                bus_err,
   output logic [ERR_CODE_W-1:0]               err_code,
   output logic [`COUNT_W-1:0]                 count_bus
);

   rx_word_u word_q;   // word of the bus being served

   // reset value decodes as an empty message word, so all outputs read 0
   always_ff @(posedge clock) begin
      if (rst) begin
         word_q <= '0;
      end else if (capture) begin
         word_q <= readdata_bus[bus_rec_select];
      end
   end

   // the kind bit picks the view
   always_comb begin
      readdata = word_q.raw;
      node_id  = '0;
      bus_err  = 1'b0;
      err_code = '0;
      if (word_q.msg.kind == KIND_STATUS) begin
         bus_err  = 1'b1;
         err_code = word_q.status.err_code;
      end else begin
         node_id  = word_q.msg.node_id;
      end
   end

   // only message words count, status words are just flagged
   always_ff @(posedge clock) begin
      if (rst) begin
         count_bus <= '0;
      end else if (deliver && word_q.msg.kind == KIND_MSG) begin
         count_bus <= count_bus + 1'b1;   // wraps at 32
      end
   end

endmodule

/* logic/can_rec_hub.sv */
`timescale 1ns/10ps
`include "mopshub_defs.svh"

module can_rec_hub
   import can_bus_pkg::*;
(
   input  logic                              clock,
   input  logic                              rst,
   input  logic [`NUM_BUS-1:0]               can_rec,
   input  logic [`NUM_BUS-1:0][`WORD_W-1:0]  readdata_bus,
   input  logic                              ireqsucrec,
   input  logic                              endwait,
   input  logic                              restirq,
   output logic [`BUS_IDX_W-1:0]             bus_rec_select,
   output logic                              init_bus_select,
   output logic [`WORD_W-1:0]                readdata,
   output logic [NODE_ID_W-1:0]              node_id,
   output logic                              bus_err,
   output logic [ERR_CODE_W-1:0]             err_code,
   output logic                              irq_can_rec,
   output logic                              choose_bus_end,
   output logic [`COUNT_W-1:0]               count_bus
);

   logic [`BUS_IDX_W-1:0] next_bus;
   logic                  any_pending;
   logic                  capture;
   logic                  deliver;   // doubles as served for the scanner

   bus_req_scanner u_scanner (
      .clock       (clock),
      .rst         (rst),
      .can_rec     (can_rec),
      .served      (deliver),
      .served_bus  (bus_rec_select),
      .next_bus    (next_bus),
      .any_pending (any_pending)
   );

   node_readdata_sm u_read_sm (
      .clock           (clock),
      .rst             (rst),
      .ireqsucrec      (ireqsucrec),
      .endwait         (endwait),
      .restirq         (restirq),
      .any_pending     (any_pending),
      .next_bus        (next_bus),
      .bus_rec_select  (bus_rec_select),
      .init_bus_select (init_bus_select),
      .capture         (capture),
      .irq_can_rec     (irq_can_rec),
      .choose_bus_end  (choose_bus_end),
      .deliver         (deliver)
   );

   rx_word_sink u_sink (
      .clock          (clock),
      .rst            (rst),
      .readdata_bus   (readdata_bus),
      .bus_rec_select (bus_rec_select),
      .capture        (capture),
      .deliver        (deliver),
      .readdata       (readdata),
      .node_id        (node_id),
      .bus_err        (bus_err),
      .err_code       (err_code),
      .count_bus      (count_bus)
   );

endmodule

/* tests/can_rec_hub_assertions.sv */
`timescale 1ns/10ps
`include "mopshub_defs.svh"

module can_rec_hub_assertions (
   input logic                  clock,
   input logic                  rst,
   input logic                  endwait,
   input logic                  restirq,
   input logic [`BUS_IDX_W-1:0] bus_rec_select,
   input logic                  init_bus_select,
   input logic                  irq_can_rec,
   input logic                  choose_bus_end
);

   // select pulse, then capture, then the interrupt
   a_init_to_irq: assert property (@(posedge clock) disable iff (rst)
      init_bus_select |-> ##2 irq_can_rec)
      else $error("irq_can_rec did not follow init_bus_select after 2 cycles");

   // only the host can drop the interrupt
   a_irq_held: assert property (@(posedge clock) disable iff (rst)
      (irq_can_rec && !endwait && !restirq) |=> irq_can_rec)
      else $error("irq_can_rec fell without endwait or restirq");

   a_end_excl: assert property (@(posedge clock) disable iff (rst)
      !(choose_bus_end && irq_can_rec))
      else $error("choose_bus_end and irq_can_rec high together");

   a_sel_stable: assert property (@(posedge clock) disable iff (rst)
      irq_can_rec |=> $stable(bus_rec_select))
      else $error("bus_rec_select changed while irq_can_rec was high");

endmodule

/* tests/tb_can_rec_hub.sv */
`timescale 1ns/10ps
`include "mopshub_defs.svh"

module tb_can_rec_hub
   import can_bus_pkg::*;
();

   localparam int PERIOD    = 20;
   localparam int N_ENTRIES = 14;
   localparam int MAX_WAIT  = 7;    // host cycles in RD_IRQ
   localparam int MARGIN    = 30;   // per entry for the fixed part of a read

   logic                             clock;
   logic                             rst;
   logic [`NUM_BUS-1:0]              can_rec;
   logic [`NUM_BUS-1:0][`WORD_W-1:0] readdata_bus;
   logic                             ireqsucrec;
   logic                             endwait;
   logic                             restirq;
   logic [`BUS_IDX_W-1:0]            bus_rec_select;
   logic                             init_bus_select;
   logic [`WORD_W-1:0]               readdata;
   logic [NODE_ID_W-1:0]             node_id;
   logic                             bus_err;
   logic [ERR_CODE_W-1:0]            err_code;
   logic                             irq_can_rec;
   logic                             choose_bus_end;
   logic [`COUNT_W-1:0]              count_bus;

   // new pending flags, abort instead of accept, host enable
   logic [31:0] tbl_mask [N_ENTRIES] = '{32'h0000_0008, 32'h0010_0082, 32'h0, 32'h0,
                                         32'h8000_0001, 32'h0, 32'h0, 32'h0,
                                         32'h0000_0224, 32'h0, 32'h0, 32'h0,
                                         32'h0000_0840, 32'h0};
   bit          tbl_abort [N_ENTRIES] = '{0, 0, 0, 0, 0, 0, 1, 0, 1, 0, 0, 0, 0, 0};
   bit          tbl_en    [N_ENTRIES] = '{1, 1, 1, 1, 0, 1, 1, 1, 1, 1, 1, 1, 1, 1};

   int          model_ptr;
   int          model_count;
   int          retry_bus;

   can_rec_hub DUT (.*);

   bind node_readdata_sm can_rec_hub_assertions u_sm_assertions (.*);

   always #(PERIOD/2) clock = ~clock;

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                        input string msg);
      if (actual !== expected) begin
         $display("mismatch at %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
         $display(">>> FAIL");
         $fatal(1, "check failed");
      end
   endtask

   // inputs change and outputs are read 2 ns after the edge
   task automatic next_cycle();
      @(posedge clock);
      #2;
   endtask

   // reference round robin from start on
   function automatic int next_pending(input logic [31:0] mask, input int start);
      int idx;
      for (int i = 0; i < `NUM_BUS; i++) begin
         idx = (start + i) % `NUM_BUS;
         if (mask[idx]) return idx;
      end
      return -1;
   endfunction

   task automatic wait_for_select();
      for (int i = 0; i < 10; i++) begin
         next_cycle();
         if (init_bus_select) return;
      end
      $display("no bus was selected although a request was pending");
      $display(">>> FAIL");
      $fatal(1, "select timeout");
   endtask

   task automatic serve_entry(input int e);
      rx_word_u w;
      int       exp_bus;
      int       wait_len;
      can_rec    = can_rec | tbl_mask[e];
      ireqsucrec = 1'b1;
      exp_bus    = next_pending(can_rec, model_ptr);
      w          = readdata_bus[exp_bus];
      wait_for_select();
      if (retry_bus >= 0) begin
         check(bus_rec_select, retry_bus, "same bus after abort");
      end else begin
         check(bus_rec_select, exp_bus, "round robin order");
      end
      retry_bus = -1;
      next_cycle();
      check(irq_can_rec, 1'b0, "irq too early");
      next_cycle();
      check(irq_can_rec, 1'b1, "irq 2 cycles after select");
      check(readdata, w.raw, "readdata");
      check(bus_err, w.msg.kind == KIND_STATUS, "bus_err");
      check(node_id, (w.msg.kind == KIND_MSG) ? w.msg.node_id : '0, "node_id");
      check(err_code, (w.msg.kind == KIND_STATUS) ? w.status.err_code : '0, "err_code");
      wait_len = $urandom % (MAX_WAIT + 1);
      repeat (wait_len) begin
         next_cycle();
         check(irq_can_rec, 1'b1, "irq held by host");
         check(choose_bus_end, 1'b0, "choose_bus_end while waiting");
      end
      if (tbl_abort[e]) begin
         restirq = 1'b1;
         next_cycle();
         restirq    = 1'b0;
         ireqsucrec = 1'b0;
         retry_bus  = exp_bus;   // flag and pointer both stay
         check(irq_can_rec, 1'b0, "irq after restirq");
         check(choose_bus_end, 1'b0, "choose_bus_end on abort");
      end else begin
         endwait = 1'b1;
         next_cycle();
         endwait    = 1'b0;
         ireqsucrec = 1'b0;
         check(irq_can_rec, 1'b0, "irq after endwait");
         check(choose_bus_end, 1'b1, "choose_bus_end pulse");
         can_rec[exp_bus] = 1'b0;   // bus controller sees its word taken
         model_ptr = (exp_bus + 1) % `NUM_BUS;
         if (w.msg.kind == KIND_MSG) model_count = (model_count + 1) % 32;
      end
      next_cycle();
      check(choose_bus_end, 1'b0, "choose_bus_end lasts one cycle");
      check(count_bus, model_count, "count_bus");
   endtask

   task automatic hold_entry(input int e);
      can_rec    = can_rec | tbl_mask[e];
      ireqsucrec = 1'b0;
      repeat (6) begin
         next_cycle();
         check(init_bus_select, 1'b0, "select while ireqsucrec low");
         check(irq_can_rec, 1'b0, "irq while ireqsucrec low");
      end
   endtask

   initial begin
      #((N_ENTRIES * (MAX_WAIT + MARGIN) + 20) * PERIOD);
      $display("the run timed out before all table entries were applied");
      $display(">>> FAIL");
      $fatal(1, "watchdog");
   end

   initial begin
      void'($urandom(32'h6e29_aeaa));
      clock      = 1'b0;
      rst        = 1'b1;
      can_rec    = '0;
      ireqsucrec = 1'b0;
      endwait    = 1'b0;
      restirq    = 1'b0;
      // odd buses carry status words, even buses message words
      for (int i = 0; i < `NUM_BUS; i++) begin
         readdata_bus[i]     = $urandom;
         readdata_bus[i][15] = i[0];
      end
      model_ptr   = 0;
      model_count = 0;
      retry_bus   = -1;
      repeat (4) @(posedge clock);
      #2;
      rst = 1'b0;
      check(irq_can_rec, 1'b0, "reset irq_can_rec");
      check(init_bus_select, 1'b0, "reset init_bus_select");
      check(choose_bus_end, 1'b0, "reset choose_bus_end");
      check(count_bus, 0, "reset count_bus");
      check(readdata, 0, "reset readdata");
      check(node_id, 0, "reset node_id");
      check(bus_err, 1'b0, "reset bus_err");
      check(err_code, 0, "reset err_code");
      for (int e = 0; e < N_ENTRIES; e++) begin
         if (tbl_en[e]) serve_entry(e);
         else hold_entry(e);
      end
      $display(">>> PASS");
      $finish;
   end

endmodule

/* sim.f */
+incdir+include
logic/can_bus_pkg.sv
logic/hub_ctrl_pkg.sv
logic/bus_req_scanner.sv
logic/node_readdata_sm.sv
logic/rx_word_sink.sv
logic/can_rec_hub.sv
tests/can_rec_hub_assertions.sv
tests/tb_can_rec_hub.sv

/* Bender.yml */
package:
  name: can_rec_hub

sources:
  - include_dirs:
      - include
    files:
      - logic/can_bus_pkg.sv
      - logic/hub_ctrl_pkg.sv
      - logic/bus_req_scanner.sv
      - logic/node_readdata_sm.sv
      - logic/rx_word_sink.sv
      - logic/can_rec_hub.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tests/can_rec_hub_assertions.sv
      - tests/tb_can_rec_hub.sv
